// File: branch_predictor.sv
`timescale 1ns/10ps

module branch_predictor #(
    parameter int bp_entries_log2 = 7
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [rv_fetch_pkg::addr_w-1:0] rd_pc,
    input  logic                            upd_en,
    input  logic [rv_fetch_pkg::addr_w-1:0] upd_pc,
    input  logic                            upd_taken,
    output logic                            taken
);
    import rv_fetch_pkg::*;

    localparam int entries = 2 ** bp_entries_log2;

    logic [1:0]                 ctr [entries];
    logic [bp_entries_log2-1:0] rd_idx;
    logic [bp_entries_log2-1:0] upd_idx;
    logic [1:0]                 cur_ctr;
    logic [1:0]                 new_ctr;

    // word aligned pc, skip bits [1:0]
    assign rd_idx  = rd_pc[bp_entries_log2+1:2];
    assign upd_idx = upd_pc[bp_entries_log2+1:2];

    assign taken   = ctr[rd_idx][1];
    assign cur_ctr = ctr[upd_idx];

    // saturating step toward the outcome
    always_comb begin
        new_ctr = cur_ctr;
        if (upd_taken) begin
            if (cur_ctr != ctr_strong_t) begin
                new_ctr = cur_ctr + 2'd1;
            end
        end else begin
            if (cur_ctr != ctr_strong_nt) begin
                new_ctr = cur_ctr - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                ctr[i] <= ctr_weak_nt;
            end
        end else if (upd_en) begin
            ctr[upd_idx] <= new_ctr;
        end
    end

endmodule

// File: fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit #(
    parameter int fifo_depth_log2 = 5
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              clr,
    input  logic [rv_fetch_pkg::addr_w-1:0]   redirect_pc,
    input  logic                              stall,
    input  logic                              ic_done,
    input  logic [rv_fetch_pkg::inst_w-1:0]   ic_inst,
    input  logic                              bp_taken,
    output logic                              ic_en,
    output logic [rv_fetch_pkg::addr_w-1:0]   ic_pc,
    output logic                              dec_en,
    output logic [rv_fetch_pkg::inst_w-1:0]   dec_inst,
    output logic [rv_fetch_pkg::addr_w-1:0]   dec_pc,
    output logic                              dec_pd
);
    import rv_fetch_pkg::*;

    localparam int depth = 2 ** fifo_depth_log2;

    logic [addr_w-1:0]          pc;
    logic [addr_w-1:0]          next_pc;
    logic [addr_w-1:0]          j_imm;
    logic [addr_w-1:0]          b_imm;
    logic [6:0]                 opcode;
    logic                       is_branch;
    logic                       pd_in;

    // instruction queue
    logic [inst_w-1:0]          q_inst [depth];
    logic [addr_w-1:0]          q_pc   [depth];
    logic                       q_pd   [depth];
    logic [fifo_depth_log2-1:0] wr_ptr;
    logic [fifo_depth_log2-1:0] rd_ptr;
    logic [depth-1:0]           occupied;
    logic                       full;
    logic                       empty;
    logic                       pop;

    // set when a request was cut off by clr and its done is still to come
    logic                       discard;

    assign ic_pc = pc;

    assign full  = &occupied;
    assign empty = ~|occupied;
    assign pop   = !empty && !stall;

    assign opcode    = ic_inst[6:0];
    assign is_branch = (opcode == op_branch);
    assign pd_in     = bp_taken && is_branch;

    assign j_imm = {{12{ic_inst[31]}}, ic_inst[19:12], ic_inst[20], ic_inst[30:21], 1'b0};
    assign b_imm = {{20{ic_inst[31]}}, ic_inst[7], ic_inst[30:25], ic_inst[11:8], 1'b0};

    always_comb begin
        if (opcode == op_jal) begin
            next_pc = pc + j_imm;
        end else if (pd_in) begin
            next_pc = pc + b_imm;
        end else begin
            next_pc = pc + next_pc_step;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            ic_en    <= 1'b0;
            discard  <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            occupied <= '0;
            dec_en   <= 1'b0;
        end else if (clr) begin
            pc       <= redirect_pc;
            ic_en    <= 1'b0;
            // cache keeps working on an accepted request
            discard  <= (ic_en || discard) && !ic_done;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            occupied <= '0;
            dec_en   <= 1'b0;
        end else begin
            if (ic_done) begin
                ic_en <= 1'b0;
                if (discard) begin
                    discard <= 1'b0;
                end else begin
                    pc               <= next_pc;
                    wr_ptr           <= wr_ptr + 1'b1;
                    occupied[wr_ptr] <= 1'b1;
                end
            end else if (!ic_en && !discard && !full) begin
                ic_en <= 1'b1;
            end

            dec_en <= pop;
            if (pop) begin
                rd_ptr           <= rd_ptr + 1'b1;
                occupied[rd_ptr] <= 1'b0;
            end
        end
    end

    // queue storage and decoder payload
    always_ff @(posedge clk) begin
        if (ic_done && !discard) begin
            q_inst[wr_ptr] <= ic_inst;
            q_pc[wr_ptr]   <= pc;
            q_pd[wr_ptr]   <= pd_in;
        end
        if (pop) begin
            dec_inst <= q_inst[rd_ptr];
            dec_pc   <= q_pc[rd_ptr];
            dec_pd   <= q_pd[rd_ptr];
        end
    end

endmodule

// File: icache.sv
`timescale 1ns/10ps

module icache #(
    parameter int icache_lines_log2 = 6
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            en,
    input  logic [rv_fetch_pkg::addr_w-1:0] pc,
    input  logic                            mem_ack,
    input  logic [rv_fetch_pkg::inst_w-1:0] mem_rdata,
    output logic                            done,
    output logic [rv_fetch_pkg::inst_w-1:0] inst,
    output logic                            mem_req,
    output logic [rv_fetch_pkg::addr_w-1:0] mem_addr
);
    import rv_fetch_pkg::*;

    localparam int lines = 2 ** icache_lines_log2;
    localparam int tag_w = addr_w - icache_lines_log2 - 2;

    logic [lines-1:0]             valid;
    logic [tag_w-1:0]             tag_mem  [lines];
    logic [inst_w-1:0]            data_mem [lines];

    logic [icache_lines_log2-1:0] idx;
    logic [tag_w-1:0]             tag_in;
    logic [icache_lines_log2-1:0] refill_idx;
    logic [tag_w-1:0]             refill_tag;
    logic                         hit;
    logic                         refilling;
    logic                         lookup;

    assign idx    = pc[icache_lines_log2+1:2];
    assign tag_in = pc[addr_w-1:icache_lines_log2+2];
    assign hit    = valid[idx] && (tag_mem[idx] == tag_in);

    // mem_addr keeps the missed pc for the whole refill
    assign refill_idx = mem_addr[icache_lines_log2+1:2];
    assign refill_tag = mem_addr[addr_w-1:icache_lines_log2+2];

    // en is still high in the done cycle, so skip it there
    assign lookup = !refilling && en && !done;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid     <= '0;
            refilling <= 1'b0;
            mem_req   <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (refilling) begin
                if (mem_ack) begin
                    mem_req           <= 1'b0;
                    refilling         <= 1'b0;
                    done              <= 1'b1;
                    valid[refill_idx] <= 1'b1;
                end
            end else if (lookup) begin
                if (hit) begin
                    done <= 1'b1;
                end else begin
                    refilling <= 1'b1;
                    mem_req   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup) begin
            inst     <= data_mem[idx];
            mem_addr <= pc;
        end
        if (refilling && mem_ack) begin
            inst                 <= mem_rdata;
            tag_mem[refill_idx]  <= refill_tag;
            data_mem[refill_idx] <= mem_rdata;
        end
    end

endmodule

// File: mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter #(
    parameter int mem_words_log2 = 10
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            d_req,
    input  logic                            d_we,
    input  logic [rv_fetch_pkg::addr_w-1:0] d_addr,
    input  logic [rv_fetch_pkg::inst_w-1:0] d_wdata,
    input  logic                            i_req,
    input  logic [rv_fetch_pkg::addr_w-1:0] i_addr,
    input  logic [rv_fetch_pkg::inst_w-1:0] m_rdata,
    output logic                            d_ack,
    output logic [rv_fetch_pkg::inst_w-1:0] d_rdata,
    output logic                            i_ack,
    output logic [rv_fetch_pkg::inst_w-1:0] i_rdata,
    output logic                            m_en,
    output logic                            m_we,
    output logic [mem_words_log2-1:0]       m_addr,
    output logic [rv_fetch_pkg::inst_w-1:0] m_wdata
);

    typedef enum logic [1:0] {
        arb_idle,
        arb_mem,
        arb_ack
    } arb_state_t;

    arb_state_t state;
    logic       grant_d;
    logic       start;

    // no new grant until the owner has seen its ack and dropped req
    assign start = (state == arb_idle) && (d_req || i_req);

    // registered word from memory is valid in the ack cycle
    assign d_rdata = m_rdata;
    assign i_rdata = m_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= arb_idle;
            grant_d <= 1'b0;
            m_en    <= 1'b0;
            m_we    <= 1'b0;
            d_ack   <= 1'b0;
            i_ack   <= 1'b0;
        end else begin
            m_en  <= 1'b0;
            m_we  <= 1'b0;
            d_ack <= 1'b0;
            i_ack <= 1'b0;
            case (state)
                arb_idle: begin
                    if (start) begin
                        // data port wins
                        grant_d <= d_req;
                        m_en    <= 1'b1;
                        m_we    <= d_req && d_we;
                        state   <= arb_mem;
                    end
                end
                arb_mem: begin
                    d_ack <= grant_d;
                    i_ack <= !grant_d;
                    state <= arb_ack;
                end
                default: begin
                    state <= arb_idle;
                end
            endcase
        end
    end

    // byte address to word index
    always_ff @(posedge clk) begin
        if (start) begin
            m_addr  <= d_req ? d_addr[mem_words_log2+1:2] : i_addr[mem_words_log2+1:2];
            m_wdata <= d_wdata;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the fetch front end testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_rv_fetch_top -f rv_fetch.f -o sim_rv_fetch
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_rv_fetch)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

// File: rv_fetch.f
rv_fetch_pkg.sv
fetch_unit.sv
branch_predictor.sv
icache.sv
mem_arbiter.sv
word_mem.sv
rv_fetch_top.sv
rv_fetch_top_asserts.sv
tb_rv_fetch_top.sv

// File: rv_fetch_pkg.sv
package rv_fetch_pkg;

    // datapath widths
    localparam int addr_w = 32;
    localparam int inst_w = 32;

    // rv32i major opcodes, bits [6:0]
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;

    // fall-through step, one word
    localparam logic [addr_w-1:0] next_pc_step = 32'd4;

    // two-bit counter states
    // upper bit set means predict taken
    localparam logic [1:0] ctr_strong_nt = 2'b00;
    localparam logic [1:0] ctr_weak_nt   = 2'b01;
    localparam logic [1:0] ctr_strong_t  = 2'b11;

endpackage

// File: rv_fetch_top.sv
`timescale 1ns/10ps

module rv_fetch_top #(
    parameter int fifo_depth_log2   = 5,
    parameter int icache_lines_log2 = 6,
    parameter int bp_entries_log2   = 7,
    parameter int mem_words_log2    = 10
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            clr,
    input  logic [rv_fetch_pkg::addr_w-1:0] redirect_pc,
    input  logic                            stall,
    input  logic                            bp_upd_en,
    input  logic [rv_fetch_pkg::addr_w-1:0] bp_upd_pc,
    input  logic                            bp_upd_taken,
    input  logic                            d_req,
    input  logic                            d_we,
    input  logic [rv_fetch_pkg::addr_w-1:0] d_addr,
    input  logic [rv_fetch_pkg::inst_w-1:0] d_wdata,
    output logic                            d_ack,
    output logic [rv_fetch_pkg::inst_w-1:0] d_rdata,
    output logic                            dec_en,
    output logic [rv_fetch_pkg::inst_w-1:0] dec_inst,
    output logic [rv_fetch_pkg::addr_w-1:0] dec_pc,
    output logic                            dec_pd
);
    import rv_fetch_pkg::*;

    logic                      ic_en;
    logic [addr_w-1:0]         ic_pc;
    logic                      ic_done;
    logic [inst_w-1:0]         ic_inst;
    logic                      bp_taken;

    logic                      i_req;
    logic [addr_w-1:0]         i_addr;
    logic                      i_ack;
    logic [inst_w-1:0]         i_rdata;

    logic                      m_en;
    logic                      m_we;
    logic [mem_words_log2-1:0] m_addr;
    logic [inst_w-1:0]         m_wdata;
    logic [inst_w-1:0]         m_rdata;

    fetch_unit #(
        .fifo_depth_log2(fifo_depth_log2)
    ) fetch_unit_inst (
        .clk(clk),
        .rst(rst),
        .clr(clr),
        .redirect_pc(redirect_pc),
        .stall(stall),
        .ic_done(ic_done),
        .ic_inst(ic_inst),
        .bp_taken(bp_taken),
        .ic_en(ic_en),
        .ic_pc(ic_pc),
        .dec_en(dec_en),
        .dec_inst(dec_inst),
        .dec_pc(dec_pc),
        .dec_pd(dec_pd)
    );

    // predictor looks up the pc being fetched
    branch_predictor #(
        .bp_entries_log2(bp_entries_log2)
    ) branch_predictor_inst (
        .clk(clk),
        .rst(rst),
        .rd_pc(ic_pc),
        .upd_en(bp_upd_en),
        .upd_pc(bp_upd_pc),
        .upd_taken(bp_upd_taken),
        .taken(bp_taken)
    );

    icache #(
        .icache_lines_log2(icache_lines_log2)
    ) icache_inst (
        .clk(clk),
        .rst(rst),
        .en(ic_en),
        .pc(ic_pc),
        .mem_ack(i_ack),
        .mem_rdata(i_rdata),
        .done(ic_done),
        .inst(ic_inst),
        .mem_req(i_req),
        .mem_addr(i_addr)
    );

    mem_arbiter #(
        .mem_words_log2(mem_words_log2)
    ) mem_arbiter_inst (
        .clk(clk),
        .rst(rst),
        .d_req(d_req),
        .d_we(d_we),
        .d_addr(d_addr),
        .d_wdata(d_wdata),
        .i_req(i_req),
        .i_addr(i_addr),
        .m_rdata(m_rdata),
        .d_ack(d_ack),
        .d_rdata(d_rdata),
        .i_ack(i_ack),
        .i_rdata(i_rdata),
        .m_en(m_en),
        .m_we(m_we),
        .m_addr(m_addr),
        .m_wdata(m_wdata)
    );

    word_mem #(
        .mem_words_log2(mem_words_log2)
    ) word_mem_inst (
        .clk(clk),
        .en(m_en),
        .we(m_we),
        .addr(m_addr),
        .wdata(m_wdata),
        .rdata(m_rdata)
    );

endmodule

// File: rv_fetch_top_asserts.sv
`timescale 1ns/10ps

module rv_fetch_top_asserts (
    input logic clk,
    input logic rst,
    input logic clr,
    input logic stall,
    input logic ic_en,
    input logic ic_done,
    input logic d_req,
    input logic i_req,
    input logic d_ack,
    input logic i_ack,
    input logic dec_en
);

    // request stays up until the cache answers or clr cancels it
    ic_en_hold: assert property (@(posedge clk) disable iff (rst)
        (ic_en && !ic_done && !clr) |=> ic_en)
        else $error("ic_en dropped before ic_done");

    // an ack goes to one requester and only to one that asked for it
    ack_exclusive: assert property (@(posedge clk) disable iff (rst)
        (d_ack || i_ack) |-> (d_ack != i_ack) && (d_ack ? $past(d_req) : $past(i_req)))
        else $error("memory ack went to both requesters or to one without a request");

    no_dec_after_stall: assert property (@(posedge clk) disable iff (rst)
        dec_en |-> !$past(stall))
        else $error("dec_en high after a stalled cycle");

    d_ack_pulse: assert property (@(posedge clk) disable iff (rst)
        d_ack |=> !d_ack)
        else $error("d_ack longer than one cycle");

    i_ack_pulse: assert property (@(posedge clk) disable iff (rst)
        i_ack |=> !i_ack)
        else $error("i_ack longer than one cycle");

endmodule

bind rv_fetch_top rv_fetch_top_asserts rv_fetch_top_asserts_inst (
    .clk(clk),
    .rst(rst),
    .clr(clr),
    .stall(stall),
    .ic_en(ic_en),
    .ic_done(ic_done),
    .d_req(d_req),
    .i_req(i_req),
    .d_ack(d_ack),
    .i_ack(i_ack),
    .dec_en(dec_en)
);

// File: tb_rv_fetch_top.sv
`timescale 1ns/10ps

module tb_rv_fetch_top;
    import rv_fetch_pkg::*;

    localparam int fifo_log2      = 5;
    localparam int icache_log2    = 6;
    localparam int bp_log2        = 7;
    localparam int mem_log2       = 10;
    localparam int timeout_cycles = 400;
    localparam int long_stall     = 250;

    localparam logic [1:0] k_plain  = 2'd0;
    localparam logic [1:0] k_jal    = 2'd1;
    localparam logic [1:0] k_branch = 2'd2;

    logic              clk;
    logic              rst;
    logic              clr;
    logic [addr_w-1:0] redirect_pc;
    logic              stall;
    logic              bp_upd_en;
    logic [addr_w-1:0] bp_upd_pc;
    logic              bp_upd_taken;
    logic              d_req;
    logic              d_we;
    logic [addr_w-1:0] d_addr;
    logic [inst_w-1:0] d_wdata;
    logic              d_ack;
    logic [inst_w-1:0] d_rdata;
    logic              dec_en;
    logic [inst_w-1:0] dec_inst;
    logic [addr_w-1:0] dec_pc;
    logic              dec_pd;

    // reference program, with the kind and offset of each control word
    logic [inst_w-1:0] prog      [2**mem_log2];
    logic [1:0]        kind      [2**mem_log2];
    logic [addr_w-1:0] offset    [2**mem_log2];
    logic [1:0]        ctr_model [2**bp_log2];
    logic [addr_w-1:0] load_list [$];

    logic [31:0]       lfsr_state;
    int                stall_left;
    int                mismatch_count;
    int                timeout_count;

    rv_fetch_top #(
        .fifo_depth_log2(fifo_log2),
        .icache_lines_log2(icache_log2),
        .bp_entries_log2(bp_log2),
        .mem_words_log2(mem_log2)
    ) rv_fetch_top_inst (
        .clk(clk),
        .rst(rst),
        .clr(clr),
        .redirect_pc(redirect_pc),
        .stall(stall),
        .bp_upd_en(bp_upd_en),
        .bp_upd_pc(bp_upd_pc),
        .bp_upd_taken(bp_upd_taken),
        .d_req(d_req),
        .d_we(d_we),
        .d_addr(d_addr),
        .d_wdata(d_wdata),
        .d_ack(d_ack),
        .d_rdata(d_rdata),
        .dec_en(dec_en),
        .dec_inst(dec_inst),
        .dec_pc(dec_pc),
        .dec_pd(dec_pd)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_alu();
        logic [31:0] r;
        r = lfsr_bits(25);
        return {r[24:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, op_jal};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [31:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], op_branch};
    endfunction

    function automatic logic model_pd(input logic [31:0] pc);
        return (kind[pc[mem_log2+1:2]] == k_branch) && ctr_model[pc[bp_log2+1:2]][1];
    endfunction

    function automatic logic [31:0] model_next(input logic [31:0] pc);
        if (kind[pc[mem_log2+1:2]] == k_jal || model_pd(pc)) begin
            return pc + offset[pc[mem_log2+1:2]];
        end
        return pc + 32'd4;
    endfunction

    task automatic place(input logic [31:0] addr, input logic [31:0] w,
                         input logic [1:0] k, input logic [31:0] off);
        prog[addr[mem_log2+1:2]]   = w;
        kind[addr[mem_log2+1:2]]   = k;
        offset[addr[mem_log2+1:2]] = off;
        load_list.push_back(addr);
    endtask

    task automatic place_ctl(input logic [31:0] addr, input logic [31:0] target,
                             input logic [1:0] k);
        logic [31:0] off;
        off = target - addr;
        place(addr, (k == k_jal) ? enc_jal(off) : enc_branch(off), k, off);
    endtask

    task automatic build_program();
        for (int i = 0; i < 2**mem_log2; i++) begin
            kind[i] = k_plain;
        end
        // straight block closed by a jal back to its start
        for (int i = 0; i < 12; i++) begin
            place(32'h100 + i * 4, enc_alu(), k_plain, 32'd0);
        end
        place_ctl(32'h130, 32'h100, k_jal);
        // loop with one forward branch
        place(32'h200, enc_alu(), k_plain, 32'd0);
        place(32'h204, enc_alu(), k_plain, 32'd0);
        place(32'h208, enc_alu(), k_plain, 32'd0);
        place_ctl(32'h20c, 32'h21c, k_branch);
        place(32'h210, enc_alu(), k_plain, 32'd0);
        place(32'h214, enc_alu(), k_plain, 32'd0);
        place_ctl(32'h218, 32'h200, k_jal);
        place(32'h21c, enc_alu(), k_plain, 32'd0);
        place_ctl(32'h220, 32'h200, k_jal);
        // long loop, more than a queue full
        for (int i = 0; i < 40; i++) begin
            place(32'h300 + i * 4, enc_alu(), k_plain, 32'd0);
        end
        place_ctl(32'h3a0, 32'h300, k_jal);
    endtask

    task automatic mem_access(input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int   cnt;
        logic got;
        d_req   = 1'b1;
        d_we    = we;
        d_addr  = addr;
        d_wdata = wdata;
        cnt     = 0;
        got     = 1'b0;
        while (!got && cnt < timeout_cycles) begin
            @(negedge clk);
            cnt++;
            got = d_ack;
        end
        rdata = d_rdata;
        d_req = 1'b0;
        d_we  = 1'b0;
        if (!got) begin
            timeout_count++;
            $display("%0t: timeout, the data port never acked address %h", $time, addr);
        end
    endtask

    task automatic load_program();
        logic [31:0] rd;
        for (int i = 0; i < load_list.size(); i++) begin
            mem_access(1'b1, load_list[i], prog[load_list[i][mem_log2+1:2]], rd);
        end
    endtask

    // mode 0 never stalls, mode 1 follows the lfsr
    task automatic drive_stall(input int mode);
        logic [31:0] r;
        if (mode == 0) begin
            stall = 1'b0;
        end else if (stall_left > 0) begin
            stall = 1'b1;
            stall_left--;
        end else begin
            r = lfsr_bits(6);
            if (r[5:0] == 6'h3f) begin
                stall_left = long_stall;
                stall      = 1'b1;
            end else begin
                stall = r[0];
            end
        end
    endtask

    task automatic wait_dec(input int mode, output logic seen);
        int cnt;
        cnt  = 0;
        seen = 1'b0;
        while (!seen && cnt < timeout_cycles) begin
            @(negedge clk);
            cnt++;
            seen = dec_en;
            drive_stall(mode);
        end
        if (!seen) begin
            timeout_count++;
            $display("%0t: timeout, no instruction reached the decoder", $time);
        end
    endtask

    task automatic check_stream(input logic [31:0] start_pc, input int count, input int mode);
        logic [31:0] exp_pc;
        logic        seen;
        exp_pc = start_pc;
        for (int i = 0; i < count; i++) begin
            wait_dec(mode, seen);
            if (!seen) begin
                break;
            end
            if (dec_pc !== exp_pc) begin
                mismatch_count++;
                $display("mismatch at %0t: dec_pc %h, expected %h", $time, dec_pc, exp_pc);
            end
            if (dec_inst !== prog[exp_pc[mem_log2+1:2]]) begin
                mismatch_count++;
                $display("mismatch at %0t: dec_inst %h at pc %h, expected %h",
                         $time, dec_inst, exp_pc, prog[exp_pc[mem_log2+1:2]]);
            end
            if (dec_pd !== model_pd(exp_pc)) begin
                mismatch_count++;
                $display("mismatch at %0t: dec_pd %b at pc %h", $time, dec_pd, exp_pc);
            end
            exp_pc = model_next(exp_pc);
        end
        stall = 1'b0;
    endtask

    task automatic restart(input logic [31:0] pc);
        clr         = 1'b1;
        redirect_pc = pc;
        @(negedge clk);
        clr = 1'b0;
    endtask

    task automatic train_branch(input logic [31:0] pc, input logic taken);
        logic [bp_log2-1:0] idx;
        idx          = pc[bp_log2+1:2];
        bp_upd_en    = 1'b1;
        bp_upd_pc    = pc;
        bp_upd_taken = taken;
        @(negedge clk);
        bp_upd_en = 1'b0;
        if (taken && ctr_model[idx] != 2'b11) begin
            ctr_model[idx] = ctr_model[idx] + 2'd1;
        end else if (!taken && ctr_model[idx] != 2'b00) begin
            ctr_model[idx] = ctr_model[idx] - 2'd1;
        end
    endtask

    task automatic test_sequential();
        restart(32'h100);
        check_stream(32'h100, 12, 0);
    endtask

    // three passes, the later ones hit in the cache
    task automatic test_jal_loop();
        restart(32'h100);
        check_stream(32'h100, 39, 0);
    endtask

    task automatic test_branch();
        restart(32'h200);
        check_stream(32'h200, 14, 0);
        // fetch held in clr while the counter moves to weakly taken
        clr         = 1'b1;
        redirect_pc = 32'h200;
        train_branch(32'h20c, 1'b1);
        clr = 1'b0;
        check_stream(32'h200, 14, 0);
    endtask

    task automatic test_stall();
        restart(32'h300);
        stall_left = long_stall;
        check_stream(32'h300, 100, 1);
    endtask

    task automatic test_flush();
        restart(32'h300);
        check_stream(32'h300, 5, 0);
        stall = 1'b1;
        repeat (60) @(negedge clk);
        clr         = 1'b1;
        redirect_pc = 32'h100;
        @(negedge clk);
        clr   = 1'b0;
        stall = 1'b0;
        check_stream(32'h100, 20, 0);
    endtask

    task automatic data_traffic();
        logic [31:0] vals [8];
        logic [31:0] rd;
        for (int i = 0; i < 8; i++) begin
            vals[i] = lfsr_bits(32);
            mem_access(1'b1, 32'h800 + i * 4, vals[i], rd);
        end
        for (int i = 0; i < 8; i++) begin
            mem_access(1'b0, 32'h800 + i * 4, 32'd0, rd);
            if (rd !== vals[i]) begin
                mismatch_count++;
                $display("mismatch at %0t: d_rdata %h at %h, expected %h",
                         $time, rd, 32'h800 + i * 4, vals[i]);
            end
        end
    endtask

    task automatic test_shared_mem();
        restart(32'h300);
        fork
            check_stream(32'h300, 60, 0);
            data_traffic();
        join
    endtask

    initial begin
        rst            = 1'b1;
        clr            = 1'b1;
        redirect_pc    = '0;
        stall          = 1'b0;
        bp_upd_en      = 1'b0;
        bp_upd_pc      = '0;
        bp_upd_taken   = 1'b0;
        d_req          = 1'b0;
        d_we           = 1'b0;
        d_addr         = '0;
        d_wdata        = '0;
        lfsr_state     = 32'h12a6_5551;
        stall_left     = 0;
        mismatch_count = 0;
        timeout_count  = 0;
        for (int i = 0; i < 2**bp_log2; i++) begin
            ctr_model[i] = ctr_weak_nt;
        end
        build_program();
        repeat (5) @(negedge clk);
        rst = 1'b0;
        load_program();

        test_sequential();
        test_jal_loop();
        test_branch();
        test_stall();
        test_flush();
        test_shared_mem();

        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: word_mem.sv
`timescale 1ns/10ps

module word_mem #(
    parameter int mem_words_log2 = 10
) (
    input  logic                            clk,
    input  logic                            en,
    input  logic                            we,
    input  logic [mem_words_log2-1:0]       addr,
    input  logic [rv_fetch_pkg::inst_w-1:0] wdata,
    output logic [rv_fetch_pkg::inst_w-1:0] rdata
);
    import rv_fetch_pkg::*;

    localparam int words = 2 ** mem_words_log2;

    logic [inst_w-1:0] mem [words];

    // single port with a registered read
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule
